//--- hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // ==========================================================
  // machine widths
  // ==========================================================
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // addi x0, x0, 0
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

  // ==========================================================
  // opcodes and function codes
  // ==========================================================
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  // lw and sw share the word size code
  localparam logic [2:0] F3_WORD    = 3'b010;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

  // decoded control word, one per instruction
  typedef struct packed {
    alu_op_t alu_op;
    logic    use_imm;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    branch_ne;
    logic    jump;
    logic    lui;
  } dec_ctrl_t;

endpackage

`default_nettype wire

//--- hw/rv_bus_pkg.sv
`default_nettype none

package rv_bus_pkg;

  // core side request, held until done
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic        done;
    logic [31:0] rdata;
  } mem_rsp_t;

  // apb master signals
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
  } apb_rsp_t;

endpackage

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_isa_pkg::*, rv_bus_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            issue_i,
  input  logic            redirect_i,
  input  logic [XLEN-1:0] target_i,
  output logic [31:0]     instr_o,
  output logic [XLEN-1:0] pc_o,
  output logic            instr_valid_o,
  output mem_req_t        req_o,
  input  mem_rsp_t        rsp_i
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] req_addr_q;
  logic [XLEN-1:0] buf_pc_q;
  logic [31:0]     buf_instr_q;
  logic            req_valid_q;
  logic            stale_q;
  logic            buf_valid_q;
  logic            launch;
  logic            accept;

  // one fetch outstanding at most, next one goes out once the slot frees
  assign launch = !req_valid_q && (!buf_valid_q || issue_i) && !redirect_i;
  assign accept = req_valid_q && rsp_i.done && !stale_q && !redirect_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q        <= RESET_PC;
      req_valid_q <= 1'b0;
      stale_q     <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      if (redirect_i) begin
        pc_q <= target_i;
      end else if (launch) begin
        pc_q <= pc_q + 4;
      end

      if (rsp_i.done) begin
        req_valid_q <= 1'b0;
        stale_q     <= 1'b0;
      end else if (launch) begin
        req_valid_q <= 1'b1;
      end else if (redirect_i && req_valid_q) begin
        // wrong path fetch still finishes on the bus
        stale_q <= 1'b1;
      end

      if (redirect_i) begin
        buf_valid_q <= 1'b0;
      end else if (accept) begin
        buf_valid_q <= 1'b1;
      end else if (issue_i) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // payload stays put after issue, a load in flight still decodes from it
  always_ff @(posedge clk) begin
    if (launch) begin
      req_addr_q <= pc_q;
    end
    if (accept) begin
      buf_instr_q <= rsp_i.rdata;
      buf_pc_q    <= req_addr_q;
    end else if (redirect_i) begin
      buf_instr_q <= NOP_INSTR;
    end
  end

  assign req_o.valid = req_valid_q;
  assign req_o.write = 1'b0;
  assign req_o.addr  = req_addr_q;
  assign req_o.wdata = '0;

  assign instr_o       = buf_instr_q;
  assign pc_o          = buf_pc_q;
  assign instr_valid_o = buf_valid_q;

endmodule

`default_nettype wire

//--- hw/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit import rv_isa_pkg::*; (
  input  logic [31:0]           instr_i,
  output logic [REG_ADDR_W-1:0] rs1_o,
  output logic [REG_ADDR_W-1:0] rs2_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output logic [XLEN-1:0]       imm_o,
  output dec_ctrl_t             ctrl_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd_o   = instr_i[11:7];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];

  // immediate by format
  always_comb begin
    case (opcode)
      OPC_STORE:  imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      OPC_BRANCH: imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                           instr_i[30:25], instr_i[11:8], 1'b0};
      OPC_LUI:    imm_o = {instr_i[31:12], 12'b0};
      OPC_JAL:    imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                           instr_i[20], instr_i[30:21], 1'b0};
      default:    imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
    endcase
  end

  // anything not matched below leaves every flag low
  always_comb begin
    ctrl_o        = '0;
    ctrl_o.alu_op = ALU_ADD;
    case (opcode)
      OPC_LUI: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.lui       = 1'b1;
      end
      OPC_JAL: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.jump      = 1'b1;
      end
      OPC_BRANCH: begin
        ctrl_o.branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        ctrl_o.branch_ne = (funct3 == F3_BNE);
      end
      OPC_LOAD: begin
        ctrl_o.use_imm   = 1'b1;
        ctrl_o.mem_read  = (funct3 == F3_WORD);
        ctrl_o.reg_write = (funct3 == F3_WORD);
      end
      OPC_STORE: begin
        ctrl_o.use_imm   = 1'b1;
        ctrl_o.mem_write = (funct3 == F3_WORD);
      end
      OPC_OP_IMM: begin
        ctrl_o.use_imm   = 1'b1;
        ctrl_o.reg_write = (funct3 == F3_ADD_SUB);
      end
      OPC_OP: begin
        if (funct7 == F7_BASE || (funct7 == F7_SUB && funct3 == F3_ADD_SUB)) begin
          ctrl_o.reg_write = 1'b1;
          case (funct3)
            F3_ADD_SUB: ctrl_o.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
            F3_SLT:     ctrl_o.alu_op = ALU_SLT;
            F3_XOR:     ctrl_o.alu_op = ALU_XOR;
            F3_OR:      ctrl_o.alu_op = ALU_OR;
            F3_AND:     ctrl_o.alu_op = ALU_AND;
            default:    ctrl_o.reg_write = 1'b0;
          endcase
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_isa_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic [REG_ADDR_W-1:0] raddr1_i,
  input  logic [REG_ADDR_W-1:0] raddr2_i,
  output logic [XLEN-1:0]       rdata1_o,
  output logic [XLEN-1:0]       rdata2_o,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i
);

  // x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

//--- hw/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit import rv_isa_pkg::*; (
  input  dec_ctrl_t       ctrl_i,
  input  logic [XLEN-1:0] rs1_val_i,
  input  logic [XLEN-1:0] rs2_val_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  output logic [XLEN-1:0] result_o,
  output logic            taken_o,
  output logic [XLEN-1:0] target_o
);

  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] alu_res;
  logic            equal;

  assign op2 = ctrl_i.use_imm ? imm_i : rs2_val_i;

  always_comb begin
    case (ctrl_i.alu_op)
      ALU_SUB: alu_res = rs1_val_i - op2;
      ALU_AND: alu_res = rs1_val_i & op2;
      ALU_OR:  alu_res = rs1_val_i | op2;
      ALU_XOR: alu_res = rs1_val_i ^ op2;
      ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(rs1_val_i) < $signed(op2)};
      default: alu_res = rs1_val_i + op2;
    endcase
  end

  // writeback value select, lui and jal bypass the alu
  assign result_o = ctrl_i.lui  ? imm_i :
                    ctrl_i.jump ? pc_i + 4 : alu_res;

  // branch compare
  assign equal    = (rs1_val_i == rs2_val_i);
  assign taken_o  = ctrl_i.jump || (ctrl_i.branch && (ctrl_i.branch_ne ? !equal : equal));
  assign target_o = pc_i + imm_i;

endmodule

`default_nettype wire

//--- hw/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu import rv_isa_pkg::*, rv_bus_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            start_i,
  input  dec_ctrl_t       ctrl_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output mem_req_t        req_o,
  input  mem_rsp_t        rsp_i,
  output logic            done_o,
  output logic [XLEN-1:0] rdata_o
);

  logic            valid_q;
  logic            write_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] wdata_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (start_i) begin
      valid_q <= 1'b1;
    end else if (rsp_i.done) begin
      valid_q <= 1'b0;
    end
  end

  // word accesses only, low address bits dropped
  always_ff @(posedge clk) begin
    if (start_i) begin
      write_q <= ctrl_i.mem_write;
      addr_q  <= {addr_i[XLEN-1:2], 2'b00};
      wdata_q <= wdata_i;
    end
  end

  assign req_o.valid = valid_q;
  assign req_o.write = write_q;
  assign req_o.addr  = addr_q;
  assign req_o.wdata = wdata_q;

  assign done_o  = rsp_i.done;
  assign rdata_o = rsp_i.rdata;

endmodule

`default_nettype wire

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import rv_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  mem_req_t fetch_req_i,
  output mem_rsp_t fetch_rsp_o,
  input  mem_req_t lsu_req_i,
  output mem_rsp_t lsu_rsp_o,
  output apb_req_t apb_req_o,
  input  apb_rsp_t apb_rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } arb_state_t;

  arb_state_t state_q;
  logic       owner_lsu_q;
  mem_req_t   sel_req;
  logic       xfer_done;

  assign sel_req   = owner_lsu_q ? lsu_req_i : fetch_req_i;
  assign xfer_done = (state_q == ST_ACCESS) && apb_rsp_i.pready;

  // ==========================================================
  // grant and apb phase tracking
  // ==========================================================
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      owner_lsu_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          // data side first
          if (lsu_req_i.valid) begin
            owner_lsu_q <= 1'b1;
            state_q     <= ST_SETUP;
          end else if (fetch_req_i.valid) begin
            owner_lsu_q <= 1'b0;
            state_q     <= ST_SETUP;
          end
        end
        ST_SETUP: state_q <= ST_ACCESS;
        ST_ACCESS: begin
          if (apb_rsp_i.pready) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // requester holds its fields, so they drive the bus directly
  assign apb_req_o.psel    = (state_q != ST_IDLE);
  assign apb_req_o.penable = (state_q == ST_ACCESS);
  assign apb_req_o.pwrite  = sel_req.write;
  assign apb_req_o.paddr   = sel_req.addr;
  assign apb_req_o.pwdata  = sel_req.wdata;

  // completion goes to the owner only
  assign fetch_rsp_o.done  = xfer_done && !owner_lsu_q;
  assign fetch_rsp_o.rdata = apb_rsp_i.prdata;
  assign lsu_rsp_o.done    = xfer_done && owner_lsu_q;
  assign lsu_rsp_o.rdata   = apb_rsp_i.prdata;

endmodule

`default_nettype wire

//--- hw/core_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module core_sequencer import rv_isa_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      instr_valid_i,
  input  dec_ctrl_t ctrl_i,
  input  logic      taken_i,
  input  logic      lsu_done_i,
  output logic      issue_o,
  output logic      lsu_start_o,
  output logic      rf_we_o,
  output logic      wb_sel_mem_o,
  output logic      redirect_o
);

  typedef enum logic {
    ST_READY,
    ST_MEM_WAIT
  } seq_state_t;

  seq_state_t state_q;
  logic       is_mem;

  assign is_mem = ctrl_i.mem_read || ctrl_i.mem_write;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_READY;
    end else begin
      case (state_q)
        ST_READY: begin
          if (instr_valid_i && is_mem) begin
            state_q <= ST_MEM_WAIT;
          end
        end
        ST_MEM_WAIT: begin
          if (lsu_done_i) begin
            state_q <= ST_READY;
          end
        end
        default: state_q <= ST_READY;
      endcase
    end
  end

  // non-memory ops retire in their issue cycle
  assign issue_o      = (state_q == ST_READY) && instr_valid_i;
  assign lsu_start_o  = issue_o && is_mem;
  assign redirect_o   = issue_o && !is_mem && taken_i;
  assign wb_sel_mem_o = (state_q == ST_MEM_WAIT);

  // loads write back on done, stores carry no reg_write
  assign rf_we_o = ctrl_i.reg_write &&
                   ((issue_o && !is_mem) || (wb_sel_mem_o && lsu_done_i));

endmodule

`default_nettype wire

//--- hw/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_isa_pkg::*, rv_bus_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic     clk,
  input  logic     rst_n_i,
  output apb_req_t apb_req_o,
  input  apb_rsp_t apb_rsp_i
);

  logic [31:0]           instr;
  logic [XLEN-1:0]       pc;
  logic                  instr_valid;
  logic                  issue;
  logic                  redirect;
  logic [XLEN-1:0]       target;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm;
  dec_ctrl_t             ctrl;
  logic [XLEN-1:0]       rs1_val;
  logic [XLEN-1:0]       rs2_val;
  logic [XLEN-1:0]       alu_result;
  logic                  taken;
  logic                  lsu_start;
  logic                  lsu_done;
  logic [XLEN-1:0]       lsu_rdata;
  logic                  rf_we;
  logic                  wb_sel_mem;
  logic [XLEN-1:0]       rf_wdata;
  mem_req_t              fetch_req;
  mem_rsp_t              fetch_rsp;
  mem_req_t              lsu_req;
  mem_rsp_t              lsu_rsp;

  // ==========================================================
  // front end
  // ==========================================================
  fetch_unit #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .issue_i      (issue),
    .redirect_i   (redirect),
    .target_i     (target),
    .instr_o      (instr),
    .pc_o         (pc),
    .instr_valid_o(instr_valid),
    .req_o        (fetch_req),
    .rsp_i        (fetch_rsp)
  );

  decode_unit u_decode (
    .instr_i(instr),
    .rs1_o  (rs1),
    .rs2_o  (rs2),
    .rd_o   (rd),
    .imm_o  (imm),
    .ctrl_o (ctrl)
  );

  // ==========================================================
  // execute and writeback
  // ==========================================================
  assign rf_wdata = wb_sel_mem ? lsu_rdata : alu_result;

  reg_file u_regs (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .raddr1_i(rs1),
    .raddr2_i(rs2),
    .rdata1_o(rs1_val),
    .rdata2_o(rs2_val),
    .we_i    (rf_we),
    .waddr_i (rd),
    .wdata_i (rf_wdata)
  );

  alu_unit u_alu (
    .ctrl_i   (ctrl),
    .rs1_val_i(rs1_val),
    .rs2_val_i(rs2_val),
    .imm_i    (imm),
    .pc_i     (pc),
    .result_o (alu_result),
    .taken_o  (taken),
    .target_o (target)
  );

  // address comes from the alu sum rs1 + imm
  lsu u_lsu (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .start_i(lsu_start),
    .ctrl_i (ctrl),
    .addr_i (alu_result),
    .wdata_i(rs2_val),
    .req_o  (lsu_req),
    .rsp_i  (lsu_rsp),
    .done_o (lsu_done),
    .rdata_o(lsu_rdata)
  );

  core_sequencer u_seq (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .instr_valid_i(instr_valid),
    .ctrl_i       (ctrl),
    .taken_i      (taken),
    .lsu_done_i   (lsu_done),
    .issue_o      (issue),
    .lsu_start_o  (lsu_start),
    .rf_we_o      (rf_we),
    .wb_sel_mem_o (wb_sel_mem),
    .redirect_o   (redirect)
  );

  bus_arbiter u_arb (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .fetch_req_i(fetch_req),
    .fetch_rsp_o(fetch_rsp),
    .lsu_req_i  (lsu_req),
    .lsu_rsp_o  (lsu_rsp),
    .apb_req_o  (apb_req_o),
    .apb_rsp_i  (apb_rsp_i)
  );

endmodule

`default_nettype wire

//--- sim/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ============================================================
// program constants
// ============================================================
localparam int          PROG_LEN     = 40;
localparam int          RESULT_COUNT = 13;
localparam int          OP_A         = 100;
localparam int          OP_B         = -7;
localparam logic [19:0] LUI_UPPER    = 20'h12345;
localparam int          BR_VAL       = 55;
// word index of the linking jal
localparam int          JAL_IDX      = 34;

string       result_name [0:RESULT_COUNT-1];
logic [31:0] result_exp  [0:RESULT_COUNT-1];

// ============================================================
// instruction encoders
// ============================================================
function automatic logic [31:0] addi_instr(input int rd, input int rs1, input int imm);
  return {imm[11:0], rs1[4:0], F3_ADD_SUB, rd[4:0], OPC_OP_IMM};
endfunction

function automatic logic [31:0] rtype_instr(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
  return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
endfunction

function automatic logic [31:0] lw_instr(input int rd, input int rs1, input int imm);
  return {imm[11:0], rs1[4:0], F3_WORD, rd[4:0], OPC_LOAD};
endfunction

function automatic logic [31:0] sw_instr(input int rs2, input int rs1, input int imm);
  return {imm[11:5], rs2[4:0], rs1[4:0], F3_WORD, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] branch_instr(input logic [2:0] f3, input int rs1,
                                             input int rs2, input int off);
  return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] jal_instr(input int rd, input int off);
  return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
endfunction

function automatic logic [31:0] lui_instr(input int rd, input logic [19:0] upper);
  return {upper, rd[4:0], OPC_LUI};
endfunction

// ============================================================
// program image and expected results
// ============================================================
task automatic load_program();
  logic [31:0] prog [0:PROG_LEN-1];
  int          base;
  base = word_index(RESET_PC);
  for (int i = 0; i < MEM_WORDS; i++) begin
    mem[i] = fill_word(32'(i) << 2);
  end
  // x10 points at the result area
  prog[0]  = addi_instr(10, 0, RESULT_BASE);
  prog[1]  = addi_instr(1, 0, OP_A);
  prog[2]  = addi_instr(2, 0, OP_B);
  prog[3]  = sw_instr(1, 10, 0);
  prog[4]  = rtype_instr(F7_BASE, F3_ADD_SUB, 3, 1, 2);
  prog[5]  = sw_instr(3, 10, 4);
  prog[6]  = rtype_instr(F7_SUB, F3_ADD_SUB, 4, 1, 2);
  prog[7]  = sw_instr(4, 10, 8);
  prog[8]  = rtype_instr(F7_BASE, F3_AND, 5, 1, 2);
  prog[9]  = sw_instr(5, 10, 12);
  prog[10] = rtype_instr(F7_BASE, F3_OR, 6, 1, 2);
  prog[11] = sw_instr(6, 10, 16);
  prog[12] = rtype_instr(F7_BASE, F3_XOR, 7, 1, 2);
  prog[13] = sw_instr(7, 10, 20);
  prog[14] = rtype_instr(F7_BASE, F3_SLT, 8, 2, 1);
  prog[15] = sw_instr(8, 10, 24);
  prog[16] = rtype_instr(F7_BASE, F3_SLT, 9, 1, 2);
  prog[17] = sw_instr(9, 10, 28);
  prog[18] = lui_instr(11, LUI_UPPER);
  prog[19] = sw_instr(11, 10, 32);
  // write to x0 must not stick
  prog[20] = addi_instr(0, 1, 5);
  prog[21] = sw_instr(0, 10, 36);
  prog[22] = lw_instr(12, 10, 32);
  prog[23] = addi_instr(12, 12, 1);
  prog[24] = sw_instr(12, 10, 40);
  // taken branches jump over poison stores
  prog[25] = branch_instr(F3_BEQ, 1, 1, 8);
  prog[26] = sw_instr(1, 0, POISON_ADDR);
  prog[27] = branch_instr(F3_BNE, 1, 2, 8);
  prog[28] = sw_instr(1, 0, POISON_ADDR);
  // not taken, both increments below must run
  prog[29] = branch_instr(F3_BEQ, 1, 2, 8);
  prog[30] = addi_instr(13, 0, BR_VAL);
  prog[31] = branch_instr(F3_BNE, 1, 1, 8);
  prog[32] = addi_instr(13, 13, 1);
  prog[33] = sw_instr(13, 10, 44);
  prog[JAL_IDX] = jal_instr(14, 8);
  prog[35] = sw_instr(1, 0, POISON_ADDR);
  prog[36] = sw_instr(14, 10, 48);
  prog[37] = addi_instr(15, 0, 1);
  prog[38] = sw_instr(15, 0, DONE_ADDR);
  prog[39] = jal_instr(0, 0);
  for (int i = 0; i < PROG_LEN; i++) begin
    mem[base + i] = prog[i];
  end

  result_name[0]  = "addi";
  result_exp[0]   = OP_A;
  result_name[1]  = "add";
  result_exp[1]   = OP_A + OP_B;
  result_name[2]  = "sub";
  result_exp[2]   = OP_A - OP_B;
  result_name[3]  = "and";
  result_exp[3]   = OP_A & OP_B;
  result_name[4]  = "or";
  result_exp[4]   = OP_A | OP_B;
  result_name[5]  = "xor";
  result_exp[5]   = OP_A ^ OP_B;
  result_name[6]  = "slt_true";
  result_exp[6]   = (OP_B < OP_A) ? 1 : 0;
  result_name[7]  = "slt_false";
  result_exp[7]   = (OP_A < OP_B) ? 1 : 0;
  result_name[8]  = "lui";
  result_exp[8]   = {LUI_UPPER, 12'h000};
  result_name[9]  = "x0_write";
  result_exp[9]   = 32'h0;
  result_name[10] = "load_store";
  result_exp[10]  = {LUI_UPPER, 12'h000} + 32'd1;
  result_name[11] = "branch_fall";
  result_exp[11]  = BR_VAL + 1;
  result_name[12] = "jal_link";
  result_exp[12]  = RESET_PC + 4 * JAL_IDX + 4;
endtask

`endif

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_isa_pkg::*, rv_bus_pkg::*; ();

  localparam logic [31:0] RESET_PC       = 32'h0000_0040;
  localparam logic [31:0] RESULT_BASE    = 32'h0000_0200;
  localparam logic [31:0] POISON_ADDR    = 32'h0000_03f0;
  localparam logic [31:0] DONE_ADDR      = 32'h0000_03fc;
  localparam int          MEM_WORDS      = 256;
  localparam int          TIMEOUT_CYCLES = 20000;

  logic        clk;
  logic        rst_n = 1'b0;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp = '0;

  logic [31:0] mem [0:MEM_WORDS-1];
  integer      seed = 32'h53c472a1;
  int          draw;
  int          wait_left = 0;
  int          cycles;
  int          value_errors = 0;
  int          bus_errors = 0;
  logic        timed_out = 1'b0;
  logic        done_seen = 1'b0;
  logic        first_seen = 1'b0;
  logic        reset_seen = 1'b0;
  apb_req_t    prev_req = '0;
  logic        prev_ready = 1'b0;

  function automatic int word_index(input logic [31:0] addr);
    return int'(addr[9:2]);
  endfunction

  // background content differs for every address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return 32'hc0de_0000 ^ addr;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  `include "tb_program.svh"

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  rv_core_top #(
    .RESET_PC(RESET_PC)
  ) u_dut (
    .clk      (clk),
    .rst_n_i  (rst_n),
    .apb_req_o(apb_req),
    .apb_rsp_i(apb_rsp)
  );

  // ============================================================
  // apb memory with random wait states
  // ============================================================
  always @(posedge clk) begin
    if (!rst_n) begin
      apb_rsp   <= '0;
      wait_left <= 0;
    end else if (apb_req.psel && !apb_req.penable) begin
      // pick how long the access stretches
      draw = $unsigned($random(seed)) % 4;
      if (draw == 0) begin
        apb_rsp.pready <= 1'b1;
        apb_rsp.prdata <= mem[word_index(apb_req.paddr)];
      end
      wait_left <= draw;
    end else if (apb_req.psel && apb_req.penable) begin
      if (apb_rsp.pready) begin
        apb_rsp.pready <= 1'b0;
        if (apb_req.pwrite) begin
          mem[word_index(apb_req.paddr)] = apb_req.pwdata;
        end
      end else if (wait_left == 1) begin
        apb_rsp.pready <= 1'b1;
        apb_rsp.prdata <= mem[word_index(apb_req.paddr)];
        wait_left      <= 0;
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

  // ============================================================
  // bus monitor
  // ============================================================
  always @(posedge clk) begin
    if (!rst_n) begin
      // psel is undefined until the first reset edge has gone by
      if (reset_seen) begin
        assert (!apb_req.psel) else begin
          $display("psel went high while reset was asserted");
          bus_errors++;
        end
      end
      reset_seen <= 1'b1;
      prev_req   <= '0;
      prev_ready <= 1'b0;
    end else begin
      if (apb_req.psel && !apb_req.penable && !first_seen) begin
        compare_word("first_paddr", RESET_PC, apb_req.paddr);
        assert (!apb_req.pwrite) else begin
          $display("first bus access after reset was a write instead of a fetch");
          bus_errors++;
        end
        first_seen <= 1'b1;
      end
      // open transfer must move on to access and hold its fields
      if (prev_req.psel && !(prev_req.penable && prev_ready)) begin
        assert (apb_req.psel && apb_req.penable &&
                apb_req.paddr == prev_req.paddr &&
                apb_req.pwrite == prev_req.pwrite &&
                apb_req.pwdata == prev_req.pwdata) else begin
          $display("transfer at %h dropped or changed before pready", prev_req.paddr);
          bus_errors++;
        end
      end
      if (apb_req.penable && !prev_req.penable) begin
        assert (apb_req.psel && prev_req.psel) else begin
          $display("penable rose without a setup cycle before it");
          bus_errors++;
        end
      end
      if (apb_req.psel && apb_req.penable && apb_rsp.pready && apb_req.pwrite) begin
        assert (apb_req.paddr != POISON_ADDR) else begin
          $display("a store reached the poison address, a branch or jump was not taken");
          bus_errors++;
        end
        if (apb_req.paddr == DONE_ADDR) begin
          done_seen <= 1'b1;
        end
      end
      prev_req   <= apb_req;
      prev_ready <= apb_rsp.pready;
    end
  end

  // ============================================================
  // run control and result check
  // ============================================================
  initial begin
    load_program();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    cycles = 0;
    while (!done_seen && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end

    if (!done_seen) begin
      $display("timed out after %0d cycles waiting for the store to the done address", cycles);
      timed_out = 1'b1;
    end else begin
      for (int i = 0; i < RESULT_COUNT; i++) begin
        compare_word(result_name[i], result_exp[i], mem[word_index(RESULT_BASE) + i]);
      end
      compare_word("poison_word", fill_word(POISON_ADDR), mem[word_index(POISON_ADDR)]);
    end

    $display("errors: value %0d, bus %0d, timeout %0d", value_errors, bus_errors, timed_out);
    if (value_errors == 0 && bus_errors == 0 && !timed_out) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+sim
hw/rv_isa_pkg.sv
hw/rv_bus_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/alu_unit.sv
hw/lsu.sv
hw/bus_arbiter.sv
hw/core_sequencer.sv
hw/rv_core_top.sv
sim/tb_rv_core.sv
